// ==== hdl/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath and register width
`define RV_XLEN    32

// Register file address width, 32 entries
`define RV_REG_AW  5

// ---------------------------------------------------------------------------
// Word address widths of the external memory ports
// ---------------------------------------------------------------------------
`define RV_IMEM_AW 9
`define RV_DMEM_AW 8

`endif

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

    // ALU functions
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    // Source of the value written back to rd
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_t;

endpackage

// ==== hdl/rv_pipe_if.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

// ---------------------------------------------------------------------------
// IF/ID pipeline register
// ---------------------------------------------------------------------------
interface if_id_if;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc4;
    logic [`RV_XLEN-1:0] instr;

    modport fetch  (output pc, pc4, instr);
    modport decode (input pc, pc4, instr);
    modport hazard (input instr);
endinterface

// ---------------------------------------------------------------------------
// ID/EX pipeline register
// ---------------------------------------------------------------------------
interface id_ex_if;
    logic                  regwrite;
    rv_pkg::result_src_t   result_src;
    logic                  memwrite;
    logic                  jump;
    logic                  branch;
    logic                  branch_ne;
    rv_pkg::alu_op_t       alu_op;
    logic                  alu_src;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   pc4;

    modport decode (output regwrite, result_src, memwrite, jump, branch, branch_ne,
                    alu_op, alu_src, rs1_data, rs2_data, rs1_addr, rs2_addr, rd_addr,
                    imm, pc, pc4);
    modport execute (input regwrite, result_src, memwrite, jump, branch, branch_ne,
                     alu_op, alu_src, rs1_data, rs2_data, rs1_addr, rs2_addr, rd_addr,
                     imm, pc, pc4);
    modport hazard (input result_src, rs1_addr, rs2_addr, rd_addr);
endinterface

// ---------------------------------------------------------------------------
// EX/MEM pipeline register
// ---------------------------------------------------------------------------
interface ex_mem_if;
    logic                  regwrite;
    rv_pkg::result_src_t   result_src;
    logic                  memwrite;
    logic [`RV_XLEN-1:0]   alu_result;
    logic [`RV_XLEN-1:0]   write_data;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic [`RV_XLEN-1:0]   pc4;

    modport execute (output regwrite, result_src, memwrite, alu_result, write_data,
                     rd_addr, pc4);
    modport memory (input regwrite, result_src, memwrite, alu_result, write_data,
                    rd_addr, pc4);
    modport hazard (input regwrite, rd_addr);
endinterface

// Writeback bus into the register file and the forwarding paths
interface wb_if;
    logic                  regwrite;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic [`RV_XLEN-1:0]   result;

    modport memory  (output regwrite, rd_addr, result);
    modport decode  (input regwrite, rd_addr, result);
    modport execute (input result);
    modport hazard  (input regwrite, rd_addr);
endinterface

// Stall, flush and forward controls plus the redirect from EX
interface hazard_if;
    logic                stall_f;
    logic                stall_d;
    logic                flush_d;
    logic                flush_e;
    logic [1:0]          forward_a;
    logic [1:0]          forward_b;
    logic                pcsrc;
    logic [`RV_XLEN-1:0] pc_target;

    modport hazard  (output stall_f, stall_d, flush_d, flush_e, forward_a, forward_b,
                     input pcsrc);
    modport fetch   (input stall_f, stall_d, flush_d, pcsrc, pc_target);
    modport decode  (input flush_e);
    modport execute (input forward_a, forward_b, output pcsrc, pc_target);
endinterface

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module fetch_stage (
    input  logic                   i_clk,
    input  logic                   i_rst,
    output logic [`RV_IMEM_AW-1:0] o_imem_addr,
    input  logic [`RV_XLEN-1:0]    i_imem_rdata,
    hazard_if.fetch                hz,
    if_id_if.fetch                 id
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc4;
    logic [`RV_XLEN-1:0] pc_next;

    assign pc4     = pc + 'd4;
    assign pc_next = hz.pcsrc ? hz.pc_target : pc4;

    // Word address of the current PC
    assign o_imem_addr = pc[`RV_IMEM_AW+1:2];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= '0;
        end else if (!hz.stall_f) begin
            pc <= pc_next;
        end
    end

    // IF/ID register, an all-zero word decodes as a bubble
    always_ff @(posedge i_clk) begin
        if (i_rst || hz.flush_d) begin
            id.instr <= '0;
        end else if (!hz.stall_d) begin
            id.instr <= i_imem_rdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!hz.stall_d) begin
            id.pc  <= pc;
            id.pc4 <= pc4;
        end
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module decode_stage (
    input  logic     i_clk,
    input  logic     i_rst,
    if_id_if.decode  id,
    id_ex_if.decode  ex,
    wb_if.decode     wb,
    hazard_if.decode hz
);

    localparam int NREGS = 1 << `RV_REG_AW;

    logic [`RV_XLEN-1:0]   regs [NREGS];
    rv_pkg::opcode_t       opcode;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_XLEN-1:0]   imm_i;
    logic [`RV_XLEN-1:0]   imm_s;
    logic [`RV_XLEN-1:0]   imm_b;
    logic [`RV_XLEN-1:0]   imm_j;

    // Decoded controls
    logic                  regwrite;
    rv_pkg::result_src_t   result_src;
    logic                  memwrite;
    logic                  jump;
    logic                  branch;
    logic                  alu_src;
    rv_pkg::alu_op_t       alu_op;
    logic [`RV_XLEN-1:0]   imm;

    assign opcode = rv_pkg::opcode_t'(id.instr[6:0]);
    assign funct3 = id.instr[14:12];
    assign rs1    = id.instr[19:15];
    assign rs2    = id.instr[24:20];

    assign imm_i = {{(`RV_XLEN-12){id.instr[31]}}, id.instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){id.instr[31]}}, id.instr[31:25], id.instr[11:7]};
    assign imm_b = {{(`RV_XLEN-13){id.instr[31]}}, id.instr[31], id.instr[7],
                    id.instr[30:25], id.instr[11:8], 1'b0};
    assign imm_j = {{(`RV_XLEN-21){id.instr[31]}}, id.instr[31], id.instr[19:12],
                    id.instr[20], id.instr[30:21], 1'b0};

    // Shared by register and immediate arithmetic
    function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b010:  return rv_pkg::ALU_SLT;
            3'b110:  return rv_pkg::ALU_OR;
            3'b111:  return rv_pkg::ALU_AND;
            default: return sub ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
        endcase
    endfunction

    always_comb begin
        regwrite   = 1'b0;
        result_src = rv_pkg::RES_ALU;
        memwrite   = 1'b0;
        jump       = 1'b0;
        branch     = 1'b0;
        alu_src    = 1'b0;
        alu_op     = rv_pkg::ALU_ADD;
        imm        = imm_i;
        case (opcode)
            rv_pkg::OP_R: begin
                regwrite = 1'b1;
                alu_op   = arith_op(funct3, id.instr[30]);
            end
            rv_pkg::OP_I: begin
                regwrite = 1'b1;
                alu_src  = 1'b1;
                alu_op   = arith_op(funct3, 1'b0);
            end
            rv_pkg::OP_LOAD: begin
                regwrite   = 1'b1;
                result_src = rv_pkg::RES_MEM;
                alu_src    = 1'b1;
            end
            rv_pkg::OP_STORE: begin
                memwrite = 1'b1;
                alu_src  = 1'b1;
                imm      = imm_s;
            end
            rv_pkg::OP_BRANCH: begin
                branch = 1'b1;
                alu_op = rv_pkg::ALU_SUB;
                imm    = imm_b;
            end
            rv_pkg::OP_JAL: begin
                regwrite   = 1'b1;
                result_src = rv_pkg::RES_PC4;
                jump       = 1'b1;
                imm        = imm_j;
            end
            default: begin
                // Unknown opcode stays a bubble
            end
        endcase
    end

    // -----------------------------------------------------------------------
    // Register file, x0 reads as zero, WB write visible in the same cycle
    // -----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (wb.regwrite && wb.rd_addr != '0) begin
            regs[wb.rd_addr] <= wb.result;
        end
    end

    function automatic logic [`RV_XLEN-1:0] rf_read(input logic [`RV_REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb.regwrite && wb.rd_addr == addr) begin
            return wb.result;
        end
        return regs[addr];
    endfunction

    // ID/EX register, flush clears only the control bits
    always_ff @(posedge i_clk) begin
        if (i_rst || hz.flush_e) begin
            ex.regwrite   <= 1'b0;
            ex.result_src <= rv_pkg::RES_ALU;
            ex.memwrite   <= 1'b0;
            ex.jump       <= 1'b0;
            ex.branch     <= 1'b0;
        end else begin
            ex.regwrite   <= regwrite;
            ex.result_src <= result_src;
            ex.memwrite   <= memwrite;
            ex.jump       <= jump;
            ex.branch     <= branch;
        end
    end

    always_ff @(posedge i_clk) begin
        ex.branch_ne <= funct3[0];
        ex.alu_op    <= alu_op;
        ex.alu_src   <= alu_src;
        ex.rs1_data  <= rf_read(rs1);
        ex.rs2_data  <= rf_read(rs2);
        ex.rs1_addr  <= rs1;
        ex.rs2_addr  <= rs2;
        ex.rd_addr   <= id.instr[11:7];
        ex.imm       <= imm;
        ex.pc        <= id.pc;
        ex.pc4       <= id.pc4;
    end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module execute_stage (
    input  logic      i_clk,
    input  logic      i_rst,
    id_ex_if.execute  ex,
    ex_mem_if.execute mem,
    wb_if.execute     wb,
    hazard_if.execute hz
);

    logic [`RV_XLEN-1:0] src_a;
    logic [`RV_XLEN-1:0] fwd_b;
    logic [`RV_XLEN-1:0] src_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                zero;

    // MEM over WB over the register value
    function automatic logic [`RV_XLEN-1:0] fwd_mux(input logic [1:0] sel,
                                                   input logic [`RV_XLEN-1:0] rf_val);
        case (sel)
            2'b10:   return mem.alu_result;
            2'b01:   return wb.result;
            default: return rf_val;
        endcase
    endfunction

    assign src_a = fwd_mux(hz.forward_a, ex.rs1_data);
    assign fwd_b = fwd_mux(hz.forward_b, ex.rs2_data);
    assign src_b = ex.alu_src ? ex.imm : fwd_b;

    always_comb begin
        case (ex.alu_op)
            rv_pkg::ALU_SUB: alu_result = src_a - src_b;
            rv_pkg::ALU_AND: alu_result = src_a & src_b;
            rv_pkg::ALU_OR:  alu_result = src_a | src_b;
            rv_pkg::ALU_SLT: alu_result = {{(`RV_XLEN-1){1'b0}},
                                           $signed(src_a) < $signed(src_b)};
            default:         alu_result = src_a + src_b;
        endcase
    end

    // -----------------------------------------------------------------------
    // Branch decision and redirect target
    // -----------------------------------------------------------------------
    assign zero         = (alu_result == '0);
    assign hz.pcsrc     = ex.jump | (ex.branch & (zero ^ ex.branch_ne));
    assign hz.pc_target = ex.pc + ex.imm;

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mem.regwrite   <= 1'b0;
            mem.result_src <= rv_pkg::RES_ALU;
            mem.memwrite   <= 1'b0;
        end else begin
            mem.regwrite   <= ex.regwrite;
            mem.result_src <= ex.result_src;
            mem.memwrite   <= ex.memwrite;
        end
    end

    always_ff @(posedge i_clk) begin
        mem.alu_result <= alu_result;
        mem.write_data <= fwd_b;
        mem.rd_addr    <= ex.rd_addr;
        mem.pc4        <= ex.pc4;
    end

endmodule

// ==== hdl/memory_stage.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module memory_stage (
    input  logic                   i_clk,
    input  logic                   i_rst,
    output logic                   o_dmem_we,
    output logic [`RV_DMEM_AW-1:0] o_dmem_addr,
    output logic [`RV_XLEN-1:0]    o_dmem_wdata,
    input  logic [`RV_XLEN-1:0]    i_dmem_rdata,
    ex_mem_if.memory               mem,
    wb_if.memory                   wb
);

    // MEM/WB payload
    rv_pkg::result_src_t result_src_w;
    logic [`RV_XLEN-1:0] alu_result_w;
    logic [`RV_XLEN-1:0] read_data_w;
    logic [`RV_XLEN-1:0] pc4_w;

    // Data port straight from EX/MEM
    assign o_dmem_we    = mem.memwrite;
    assign o_dmem_addr  = mem.alu_result[`RV_DMEM_AW+1:2];
    assign o_dmem_wdata = mem.write_data;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wb.regwrite <= 1'b0;
        end else begin
            wb.regwrite <= mem.regwrite;
        end
    end

    always_ff @(posedge i_clk) begin
        wb.rd_addr   <= mem.rd_addr;
        result_src_w <= mem.result_src;
        alu_result_w <= mem.alu_result;
        read_data_w  <= i_dmem_rdata;
        pc4_w        <= mem.pc4;
    end

    // -----------------------------------------------------------------------
    // Writeback result select
    // -----------------------------------------------------------------------
    always_comb begin
        case (result_src_w)
            rv_pkg::RES_MEM: wb.result = read_data_w;
            rv_pkg::RES_PC4: wb.result = pc4_w;
            default:         wb.result = alu_result_w;
        endcase
    end

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module hazard_unit (
    if_id_if.hazard  id,
    id_ex_if.hazard  ex,
    ex_mem_if.hazard mem,
    wb_if.hazard     wb,
    hazard_if.hazard hz
);

    logic [`RV_REG_AW-1:0] rs1_d;
    logic [`RV_REG_AW-1:0] rs2_d;
    logic                  lw_stall;

    // Source registers of the instruction in decode
    assign rs1_d = id.instr[19:15];
    assign rs2_d = id.instr[24:20];

    // -----------------------------------------------------------------------
    // Forwarding into EX, the youngest producer wins
    // -----------------------------------------------------------------------
    function automatic logic [1:0] fwd_sel(input logic [`RV_REG_AW-1:0] rs);
        if (rs != '0 && mem.regwrite && mem.rd_addr == rs) begin
            return 2'b10;
        end else if (rs != '0 && wb.regwrite && wb.rd_addr == rs) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    assign hz.forward_a = fwd_sel(ex.rs1_addr);
    assign hz.forward_b = fwd_sel(ex.rs2_addr);

    // Load in EX feeding the instruction in decode
    assign lw_stall = (ex.result_src == rv_pkg::RES_MEM) && (ex.rd_addr != '0) &&
                      ((ex.rd_addr == rs1_d) || (ex.rd_addr == rs2_d));

    assign hz.stall_f = lw_stall;
    assign hz.stall_d = lw_stall;

    // Redirect drops the two younger instructions
    assign hz.flush_d = hz.pcsrc;
    assign hz.flush_e = hz.pcsrc | lw_stall;

endmodule

// ==== hdl/riscv_core.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module riscv_core (
    input  logic                   i_clk,
    input  logic                   i_rst,

    // Instruction memory port
    output logic [`RV_IMEM_AW-1:0] o_imem_addr,
    input  logic [`RV_XLEN-1:0]    i_imem_rdata,

    // Data memory port
    output logic                   o_dmem_we,
    output logic [`RV_DMEM_AW-1:0] o_dmem_addr,
    output logic [`RV_XLEN-1:0]    o_dmem_wdata,
    input  logic [`RV_XLEN-1:0]    i_dmem_rdata
);

    if_id_if  u_if_id ();
    id_ex_if  u_id_ex ();
    ex_mem_if u_ex_mem ();
    wb_if     u_wb ();
    hazard_if u_hz ();

    // -----------------------------------------------------------------------
    // Pipeline stages
    // -----------------------------------------------------------------------
    fetch_stage u_fetch_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .o_imem_addr  (o_imem_addr),
        .i_imem_rdata (i_imem_rdata),
        .hz           (u_hz.fetch),
        .id           (u_if_id.fetch)
    );

    decode_stage u_decode_stage (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .id    (u_if_id.decode),
        .ex    (u_id_ex.decode),
        .wb    (u_wb.decode),
        .hz    (u_hz.decode)
    );

    execute_stage u_execute_stage (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .ex    (u_id_ex.execute),
        .mem   (u_ex_mem.execute),
        .wb    (u_wb.execute),
        .hz    (u_hz.execute)
    );

    memory_stage u_memory_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_rdata (i_dmem_rdata),
        .mem          (u_ex_mem.memory),
        .wb           (u_wb.memory)
    );

    // Stall, flush and forward control
    hazard_unit u_hazard_unit (
        .id  (u_if_id.hazard),
        .ex  (u_id_ex.hazard),
        .mem (u_ex_mem.hazard),
        .wb  (u_wb.hazard),
        .hz  (u_hz.hazard)
    );

endmodule

// ==== bench/riscv_core_chk.sv ====
`timescale 1ns/1ps

module riscv_core_chk (
    input logic i_clk,
    input logic i_rst,
    input logic i_dmem_we,
    input logic i_stall_f,
    input logic i_stall_d,
    input logic i_flush_d
);

    // Data port idle right after reset
    assert property (@(posedge i_clk) i_rst |=> !i_dmem_we)
        else $error("o_dmem_we high in the cycle after reset");

    // Fetch and decode always stall together
    assert property (@(posedge i_clk) disable iff (i_rst) i_stall_f == i_stall_d)
        else $error("stall_f and stall_d differ");

    // A load-use stall and a redirect cannot meet
    assert property (@(posedge i_clk) disable iff (i_rst) !(i_stall_d && i_flush_d))
        else $error("stall_d and flush_d asserted together");

endmodule

// ==== bench/tb_riscv_core.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_riscv_core;

    localparam int CLK_PERIOD     = 100;
    localparam int RST_CYCLES     = 16;
    localparam int PROG_LEN       = 200;
    localparam int HALT_IDX       = PROG_LEN - 1;
    localparam int RAND_END       = HALT_IDX - 7;
    localparam int LAST_JUMP      = RAND_END - 6;
    localparam int CLOSE_WORD     = 40;
    localparam int DRAIN_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + RST_CYCLES;

    // Instruction kinds of the generated program
    localparam int K_R   = 0;
    localparam int K_I   = 1;
    localparam int K_LW  = 2;
    localparam int K_SW  = 3;
    localparam int K_BEQ = 4;
    localparam int K_BNE = 5;
    localparam int K_JAL = 6;

    logic                   clk;
    logic                   rst;
    logic [`RV_IMEM_AW-1:0] imem_addr;
    logic [`RV_XLEN-1:0]    imem_rdata;
    logic                   dmem_we;
    logic [`RV_DMEM_AW-1:0] dmem_addr;
    logic [`RV_XLEN-1:0]    dmem_wdata;
    logic [`RV_XLEN-1:0]    dmem_rdata;

    logic [`RV_XLEN-1:0] imem [1 << `RV_IMEM_AW];
    logic [`RV_XLEN-1:0] dmem [1 << `RV_DMEM_AW];
    logic [`RV_XLEN-1:0] ref_mem [1 << `RV_DMEM_AW];
    logic [`RV_XLEN-1:0] ref_regs [8];

    // Program fields kept for the ISA model
    int                  p_kind [PROG_LEN];
    int                  p_fn   [PROG_LEN];
    logic [4:0]          p_rd   [PROG_LEN];
    logic [4:0]          p_rs1  [PROG_LEN];
    logic [4:0]          p_rs2  [PROG_LEN];
    logic [`RV_XLEN-1:0] p_imm  [PROG_LEN];

    logic [`RV_DMEM_AW-1:0] exp_addr [$];
    logic [`RV_XLEN-1:0]    exp_data [$];
    int                     stores_seen;
    logic [15:0]            lfsr_state;

    riscv_core UUT (
        .i_clk        (clk),
        .i_rst        (rst),
        .o_imem_addr  (imem_addr),
        .i_imem_rdata (imem_rdata),
        .o_dmem_we    (dmem_we),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata)
    );

    bind riscv_core riscv_core_chk u_core_chk (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_dmem_we (o_dmem_we),
        .i_stall_f (u_hz.stall_f),
        .i_stall_d (u_hz.stall_d),
        .i_flush_d (u_hz.flush_d)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // -----------------------------------------------------------------------
    // Checking and random helpers
    // -----------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [31:0] b);
        return {{20{b[11]}}, b[11:0]};
    endfunction

    // Forward by 2 to 6 instructions
    function automatic logic [31:0] jump_offset();
        return (32'd2 + rand_bits(3) % 5) * 4;
    endfunction

    function automatic logic [31:0] fill_word(input int w);
        return 32'h5A5A_0000 ^ (32'(w) * 32'h0001_0101);
    endfunction

    function automatic logic [2:0] funct3_of(input int fn);
        case (fn)
            2:       return 3'b111;
            3:       return 3'b110;
            4:       return 3'b010;
            default: return 3'b000;
        endcase
    endfunction

    // Reference ALU for add, sub, and, or and slt
    function automatic logic [31:0] alu_ref(input int fn, input logic [31:0] a,
                                            input logic [31:0] b);
        case (fn)
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    // -----------------------------------------------------------------------
    // Program generator
    // -----------------------------------------------------------------------
    function automatic logic [31:0] encode(input int i);
        logic [2:0]  f3;
        logic [31:0] imm;
        f3  = funct3_of(p_fn[i]);
        imm = p_imm[i];
        case (p_kind[i])
            K_R:  return {(p_fn[i] == 1) ? 7'b0100000 : 7'b0000000, p_rs2[i], p_rs1[i],
                          f3, p_rd[i], 7'b0110011};
            K_I:  return {imm[11:0], p_rs1[i], f3, p_rd[i], 7'b0010011};
            K_LW: return {imm[11:0], p_rs1[i], 3'b010, p_rd[i], 7'b0000011};
            K_SW: return {imm[11:5], p_rs2[i], p_rs1[i], 3'b010, imm[4:0], 7'b0100011};
            K_BEQ, K_BNE: return {imm[12], imm[10:5], p_rs2[i], p_rs1[i], 2'b00,
                                  p_kind[i] == K_BNE, imm[4:1], imm[11], 7'b1100011};
            K_JAL: return {imm[20], imm[10:1], imm[11], imm[19:12], p_rd[i], 7'b1101111};
            default: return 32'h0;
        endcase
    endfunction

    task automatic add_instr(input int i, input int kind, input int fn,
                             input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [31:0] imm);
        p_kind[i] = kind;
        p_fn[i]   = fn;
        p_rd[i]   = rd;
        p_rs1[i]  = rs1;
        p_rs2[i]  = rs2;
        p_imm[i]  = imm;
        imem[i]   = encode(i);
    endtask

    task automatic gen_program();
        int         op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        for (int w = 0; w < (1 << `RV_IMEM_AW); w++) begin
            imem[w] = '0;
        end
        // x1..x7 get defined values before any use
        for (int r = 1; r < 8; r++) begin
            add_instr(r - 1, K_I, 0, 5'(r), 5'd0, 5'd0, sext12(rand_bits(12)));
        end
        for (int i = 7; i < RAND_END; i++) begin
            op = rand_bits(4);
            if (op >= 13 && i > LAST_JUMP) begin
                op = 11;
            end
            rd  = 5'(rand_bits(3));
            rs1 = 5'(rand_bits(3));
            rs2 = 5'(rand_bits(3));
            if (op <= 4) begin
                add_instr(i, K_R, op, rd, rs1, rs2, '0);
            end else if (op <= 8) begin
                add_instr(i, K_I, (op == 5) ? 0 : op - 4, rd, rs1, 5'd0,
                          sext12(rand_bits(12)));
            end else if (op <= 10) begin
                add_instr(i, K_LW, 0, rd, 5'd0, 5'd0, rand_bits(5) << 2);
            end else if (op <= 12) begin
                add_instr(i, K_SW, 0, 5'd0, 5'd0, rs2, rand_bits(5) << 2);
            end else if (op == 15) begin
                add_instr(i, K_JAL, 0, rd, 5'd0, 5'd0, jump_offset());
            end else begin
                add_instr(i, (op == 13) ? K_BEQ : K_BNE, 0, 5'd0, rs1, rs2, jump_offset());
            end
        end
        // Closing stores of x1..x7 and the JAL x0,0 halt
        for (int r = 1; r < 8; r++) begin
            add_instr(RAND_END + r - 1, K_SW, 0, 5'd0, 5'd0, 5'(r), 32'((CLOSE_WORD + r) * 4));
        end
        add_instr(HALT_IDX, K_JAL, 0, 5'd0, 5'd0, 5'd0, '0);
    endtask

    // Sequential ISA model that records every store in program order
    task automatic run_model();
        int          idx;
        int          next_idx;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        for (int r = 0; r < 8; r++) begin
            ref_regs[r] = '0;
        end
        idx = 0;
        while (idx != HALT_IDX) begin
            a        = ref_regs[p_rs1[idx]];
            b        = ref_regs[p_rs2[idx]];
            next_idx = idx + 1;
            wr       = 1'b1;
            res      = '0;
            case (p_kind[idx])
                K_R:  res = alu_ref(p_fn[idx], a, b);
                K_I:  res = alu_ref(p_fn[idx], a, p_imm[idx]);
                K_LW: res = ref_mem[p_imm[idx] >> 2];
                K_SW: begin
                    wr = 1'b0;
                    ref_mem[p_imm[idx] >> 2] = b;
                    exp_addr.push_back(8'(p_imm[idx] >> 2));
                    exp_data.push_back(b);
                end
                K_JAL: begin
                    res      = (idx + 1) * 4;
                    next_idx = idx + int'(p_imm[idx] >> 2);
                end
                default: begin
                    wr = 1'b0;
                    if ((a == b) == (p_kind[idx] == K_BEQ)) begin
                        next_idx = idx + int'(p_imm[idx] >> 2);
                    end
                end
            endcase
            if (wr && p_rd[idx] != 0) begin
                ref_regs[p_rd[idx]] = res;
            end
            idx = next_idx;
        end
    endtask

    task automatic check_store(input logic [`RV_DMEM_AW-1:0] addr,
                               input logic [`RV_XLEN-1:0] data);
        if (stores_seen >= exp_addr.size()) begin
            fail_run($sformatf("Unexpected store to word %0d after all %0d expected stores",
                               addr, exp_addr.size()));
        end else begin
            compare_value("o_dmem_addr", 32'(addr), 32'(exp_addr[stores_seen]));
            compare_value("o_dmem_wdata", data, exp_data[stores_seen]);
            stores_seen++;
        end
    endtask

    // Instruction and data memory models with the store check
    always @(negedge clk) begin
        if (!rst && dmem_we === 1'b1) begin
            check_store(dmem_addr, dmem_wdata);
            dmem[dmem_addr] = dmem_wdata;
        end
        dmem_rdata <= dmem[dmem_addr];
        imem_rdata <= imem[imem_addr];
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run($sformatf("Timeout: halt not reached within %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        rst         = 1'b1;
        imem_rdata  = '0;
        dmem_rdata  = '0;
        stores_seen = 0;
        lfsr_state  = 16'd42138;
        for (int w = 0; w < (1 << `RV_DMEM_AW); w++) begin
            dmem[w]    = fill_word(w);
            ref_mem[w] = fill_word(w);
        end
        gen_program();
        run_model();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        // Fetch of the halt word marks the end
        while (imem_addr !== HALT_IDX) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        compare_value("store_count", stores_seen, exp_addr.size());
        for (int r = 1; r < 8; r++) begin
            compare_value($sformatf("dmem[%0d]", CLOSE_WORD + r), dmem[CLOSE_WORD + r],
                          ref_regs[r]);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_pipe_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_unit.sv
hdl/riscv_core.sv
bench/riscv_core_chk.sv
bench/tb_riscv_core.sv

// ==== Bender.yml ====
package:
  name: riscv_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/rv_pipe_if.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/memory_stage.sv
      - hdl/hazard_unit.sv
      - hdl/riscv_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/riscv_core_chk.sv
      - bench/tb_riscv_core.sv
